// ==== hdl/alu_defines.svh ====
// Width and register map macros shared by the ALU RTL and its testbench
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// Operand and result width, the prefix tree is generated from this
`define ALU_WIDTH 18

// Wishbone data and word address widths
`define WB_DATA_WIDTH 32
`define WB_ADDR_WIDTH 3

// Word addresses of the register map
`define REG_OP_A   3'd0
`define REG_OP_B   3'd1
`define REG_CTRL   3'd2
`define REG_RESULT 3'd3
`define REG_STATUS 3'd4

`endif

// ==== hdl/alu_pkg.sv ====
// Arithmetic types used by the ALU core and by the bus register block that feeds it
package alu_pkg;

	// Opcode taken from the low two bits of the control register
	typedef enum logic [1:0] {
		OP_ADD  = 2'd0,
		OP_ADDC = 2'd1,
		OP_SUB  = 2'd2,
		OP_INC  = 2'd3
	} alu_op_t;

	// Flags registered together with each result
	// carry means no borrow after a subtract
	typedef struct packed {
		logic carry;
		logic zero;
		logic overflow;
	} alu_flags_t;

endpackage

// ==== hdl/wb_pkg.sv ====
// Bus-side types for the Wishbone register block: address map view and slave state
`include "alu_defines.svh"

package wb_pkg;

	// Word address decoded as a register name
	typedef enum logic [`WB_ADDR_WIDTH-1:0] {
		ADDR_OP_A   = `REG_OP_A,
		ADDR_OP_B   = `REG_OP_B,
		ADDR_CTRL   = `REG_CTRL,
		ADDR_RESULT = `REG_RESULT,
		ADDR_STATUS = `REG_STATUS
	} reg_addr_t;

	// Slave FSM, one ack cycle per request
	typedef enum logic {
		ST_IDLE = 1'b0,
		ST_ACK  = 1'b1
	} wb_state_t;

endpackage

// ==== hdl/lf_prefix_tree.sv ====
// Ladner-Fischer prefix network turning bit propagate and generate into group carries
`timescale 1ns/1ps
`include "alu_defines.svh"

module lf_prefix_tree (
	input  logic [`ALU_WIDTH-1:0] prop,
	input  logic [`ALU_WIDTH-1:0] gen,
	output logic [`ALU_WIDTH-1:0] carries
);

	localparam int W = `ALU_WIDTH;
	localparam int LEVELS = $clog2(W);

	// Group generate and propagate after each level, level 0 is the input
	wire [W-1:0] gl [0:LEVELS];
	wire [W-1:0] pl [0:LEVELS];

	assign gl[0] = gen;
	assign pl[0] = prop;

	genvar k, i;
	generate
		// Sklansky-style levels over odd positions only
		for (k = 1; k <= LEVELS; k++) begin : g_level
			for (i = 0; i < W; i++) begin : g_bit
				if ((i % 2 == 1) && (((i >> (k - 1)) & 1) == 1)) begin : g_cell
					// Top of the lower half of this 2^k block
					localparam int J = ((i >> (k - 1)) << (k - 1)) - 1;

					assign gl[k][i] = gl[k-1][i] | (pl[k-1][i] & gl[k-1][J]);
					if ((i >> k) == 0) begin : g_grey
						// Group now reaches bit 0, propagate is no longer needed
						assign pl[k][i] = 1'b0;
					end else begin : g_black
						assign pl[k][i] = pl[k-1][i] & pl[k-1][J];
					end
				end else begin : g_pass
					assign gl[k][i] = gl[k-1][i];
					assign pl[k][i] = pl[k-1][i];
				end
			end
		end

		// Bit 0 is its own group
		assign carries[0] = gl[LEVELS][0];

		// Extra grey stage fills in the even positions from their odd neighbour
		for (i = 1; i < W; i++) begin : g_final
			if (i % 2 == 0) begin : g_even
				assign carries[i] = gl[LEVELS][i] | (pl[LEVELS][i] & gl[LEVELS][i-1]);
			end else begin : g_odd
				assign carries[i] = gl[LEVELS][i];
			end
		end
	endgenerate

endmodule

// ==== hdl/prefix_adder.sv ====
// Parallel-prefix adder: bit pre-computation, Ladner-Fischer tree and sum/carry-out
`timescale 1ns/1ps
`include "alu_defines.svh"

module prefix_adder (
	input  logic [`ALU_WIDTH-1:0] operand_a,
	input  logic [`ALU_WIDTH-1:0] operand_b,
	input  logic                  carry_in,
	output logic [`ALU_WIDTH-1:0] sum,
	output logic                  carry_out
);

	localparam int W = `ALU_WIDTH;

	// Propagate and generate shifted up by one, carry-in sits at position 0
	logic [W:0]   p_ext;
	logic [W:0]   g_ext;
	// carries[n] is the carry into operand bit n
	logic [W-1:0] carries;

	assign p_ext = {operand_a ^ operand_b, 1'b0};
	assign g_ext = {operand_a & operand_b, carry_in};

	lf_prefix_tree i_tree (
		.prop    (p_ext[W-1:0]),
		.gen     (g_ext[W-1:0]),
		.carries (carries)
	);

	assign sum = p_ext[W:1] ^ carries;

	// Top bit folded onto the group below it
	assign carry_out = g_ext[W] | (p_ext[W] & carries[W-1]);

endmodule

// ==== hdl/alu_core.sv ====
// Arithmetic core: conditions operands per opcode and registers result and flags on start
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_core (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  start,
	input  alu_pkg::alu_op_t      op,
	input  logic [`ALU_WIDTH-1:0] op_a,
	input  logic [`ALU_WIDTH-1:0] op_b,
	output logic [`ALU_WIDTH-1:0] result,
	output alu_pkg::alu_flags_t   flags,
	output logic                  done
);

	import alu_pkg::*;

	localparam int W = `ALU_WIDTH;

	logic [W-1:0] operand_b;
	logic         carry_in;
	logic [W-1:0] sum;
	logic         carry_out;
	logic         overflow;

	// Subtract is a + ~b + 1, increment is a + 0 + 1
	always_comb begin
		operand_b = op_b;
		carry_in  = 1'b0;
		case (op)
			OP_ADD: begin
				operand_b = op_b;
				carry_in  = 1'b0;
			end
			OP_ADDC: begin
				operand_b = op_b;
				carry_in  = flags.carry;
			end
			OP_SUB: begin
				operand_b = ~op_b;
				carry_in  = 1'b1;
			end
			OP_INC: begin
				operand_b = '0;
				carry_in  = 1'b1;
			end
		endcase
	end

	prefix_adder i_adder (
		.operand_a (op_a),
		.operand_b (operand_b),
		.carry_in  (carry_in),
		.sum       (sum),
		.carry_out (carry_out)
	);

	// Same-sign operands giving a sum of the other sign
	assign overflow = (op_a[W-1] == operand_b[W-1]) && (sum[W-1] != op_a[W-1]);

	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
			flags  <= '0;
			done   <= 1'b0;
		end else begin
			done <= start;
			if (start) begin
				result         <= sum;
				flags.carry    <= carry_out;
				flags.zero     <= ~|sum;
				flags.overflow <= overflow;
			end
		end
	end

endmodule

// ==== hdl/wb_alu_regs.sv ====
// Wishbone classic slave holding the ALU operand, control, result and status registers
`timescale 1ns/1ps
`include "alu_defines.svh"

module wb_alu_regs (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [`WB_ADDR_WIDTH-1:0] wb_adr,
	input  logic [`WB_DATA_WIDTH-1:0] wb_wdata,
	output logic [`WB_DATA_WIDTH-1:0] wb_rdata,
	output logic                      wb_ack,
	output logic [`ALU_WIDTH-1:0]     op_a,
	output logic [`ALU_WIDTH-1:0]     op_b,
	output alu_pkg::alu_op_t          op,
	output logic                      start,
	input  logic [`ALU_WIDTH-1:0]     result,
	input  alu_pkg::alu_flags_t       flags,
	input  logic                      done
);

	import alu_pkg::*;
	import wb_pkg::*;

	localparam int W  = `ALU_WIDTH;
	localparam int DW = `WB_DATA_WIDTH;

	wb_state_t       state;
	reg_addr_t       addr;
	logic            req;
	logic            wr_en;
	logic            done_sticky;
	logic [DW-1:0]   read_mux;

	assign addr  = reg_addr_t'(wb_adr);
	// A new request is only taken while idle
	assign req   = wb_cyc && wb_stb && (state == ST_IDLE);
	assign wr_en = req && wb_we;

	assign wb_ack = (state == ST_ACK);

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= ST_IDLE;
			op_a        <= '0;
			op_b        <= '0;
			op          <= OP_ADD;
			start       <= 1'b0;
			done_sticky <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (wb_cyc && wb_stb)
						state <= ST_ACK;
				end
				ST_ACK: state <= ST_IDLE;
			endcase

			if (done)
				done_sticky <= 1'b1;

			// Operand writes below win over a done in the same cycle
			if (wr_en) begin
				case (addr)
					ADDR_OP_A: begin
						op_a        <= wb_wdata[W-1:0];
						done_sticky <= 1'b0;
					end
					ADDR_OP_B: begin
						op_b        <= wb_wdata[W-1:0];
						done_sticky <= 1'b0;
					end
					ADDR_CTRL: begin
						op    <= alu_op_t'(wb_wdata[1:0]);
						start <= 1'b1;
					end
					default: ;
				endcase
			end
		end
	end

	// Status done also shows the live pulse, so a read right after an op sees it
	always_comb begin
		read_mux = '0;
		case (addr)
			ADDR_OP_A:   read_mux = DW'(op_a);
			ADDR_OP_B:   read_mux = DW'(op_b);
			ADDR_CTRL:   read_mux = DW'(op);
			ADDR_RESULT: read_mux = DW'(result);
			ADDR_STATUS: read_mux = DW'({done_sticky | done, flags.overflow,
				flags.zero, flags.carry});
			default:     read_mux = '0;
		endcase
	end

	// Read data captured with the request, valid during the ack cycle
	always_ff @(posedge clk) begin
		if (req)
			wb_rdata <= read_mux;
	end

endmodule

// ==== hdl/alu_top.sv ====
// Top level of the ALU peripheral: Wishbone register block driving the arithmetic core
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      wb_cyc,
	input  logic                      wb_stb,
	input  logic                      wb_we,
	input  logic [`WB_ADDR_WIDTH-1:0] wb_adr,
	input  logic [`WB_DATA_WIDTH-1:0] wb_wdata,
	output logic [`WB_DATA_WIDTH-1:0] wb_rdata,
	output logic                      wb_ack
);

	import alu_pkg::*;

	logic [`ALU_WIDTH-1:0] op_a;
	logic [`ALU_WIDTH-1:0] op_b;
	logic [`ALU_WIDTH-1:0] result;
	alu_op_t               op;
	alu_flags_t            flags;
	logic                  start;
	logic                  done;

	wb_alu_regs i_regs (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack),
		.op_a     (op_a),
		.op_b     (op_b),
		.op       (op),
		.start    (start),
		.result   (result),
		.flags    (flags),
		.done     (done)
	);

	alu_core i_core (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.op     (op),
		.op_a   (op_a),
		.op_b   (op_b),
		.result (result),
		.flags  (flags),
		.done   (done)
	);

endmodule

// ==== tests/alu_props.sv ====
// Concurrent checks on the Wishbone handshake and core start/done timing, bound into wb_alu_regs
`timescale 1ns/1ps

module alu_props (
	input logic              clk,
	input logic              reset,
	input logic              wb_cyc,
	input logic              wb_stb,
	input logic              wb_ack,
	input logic              start,
	input logic              done,
	input wb_pkg::wb_state_t state
);

	import wb_pkg::*;

	// Ack only in the cycle after a request taken while idle
	ack_after_request: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> $past(wb_cyc && wb_stb && state == ST_IDLE))
		else $error("wb_ack without a request in the previous cycle");

	ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else $error("wb_ack high for two cycles in a row");

	// Core registers its result one edge after start
	done_after_start: assert property (@(posedge clk) disable iff (reset)
		done == $past(start))
		else $error("done does not follow start by one cycle");

endmodule

// ==== tests/alu_tb.sv ====
// Self-checking testbench for the Wishbone ALU peripheral that runs as the simulation top
`timescale 1ns/1ps
`include "alu_defines.svh"

module alu_tb;

	import alu_pkg::*;

	localparam int W = `ALU_WIDTH;
	localparam int DW = `WB_DATA_WIDTH;
	localparam int N_RANDOM = 200;
	// Operations in the directed, random and register tests
	localparam int N_OPS = 230;
	// Five bus accesses of two cycles each per operation
	localparam int CYCLES_PER_OP = 10;
	localparam longint FULL = longint'(1) << W;
	localparam longint HALF = FULL / 2;
	localparam logic [W-1:0] MAXV = '1;
	localparam logic [W-1:0] MAXS = {1'b0, {(W-1){1'b1}}};
	localparam logic [W-1:0] MINS = {1'b1, {(W-1){1'b0}}};

	logic                      clk;
	logic                      reset;
	logic                      wb_cyc;
	logic                      wb_stb;
	logic                      wb_we;
	logic [`WB_ADDR_WIDTH-1:0] wb_adr;
	logic [DW-1:0]             wb_wdata;
	logic [DW-1:0]             wb_rdata;
	logic                      wb_ack;
	integer                    seed;
	logic                      model_carry;
	logic [W+2:0]              last_exp;
	string                     name_q[$];
	logic [DW-1:0]             act_q[$];
	logic [DW-1:0]             exp_q[$];
	event                      sample_ev;

	alu_top i_dut (
		.clk      (clk),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_wdata (wb_wdata),
		.wb_rdata (wb_rdata),
		.wb_ack   (wb_ack)
	);

	bind wb_alu_regs alu_props i_props (
		.clk    (clk),
		.reset  (reset),
		.wb_cyc (wb_cyc),
		.wb_stb (wb_stb),
		.wb_ack (wb_ack),
		.start  (start),
		.done   (done),
		.state  (state)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#((8 + N_OPS * CYCLES_PER_OP) * 4 * 10);
		$display("Timeout: the run did not finish within %0d ns", $time);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	// Expected {carry, zero, overflow, result} from unsigned and signed integer sums
	function automatic logic [W+2:0] alu_model(input alu_op_t op, input logic [W-1:0] a,
			input logic [W-1:0] b, input logic carry_prev);
		longint ua;
		longint ub;
		longint sa;
		longint sb;
		longint usum;
		longint ssum;
		logic   ovf;
		ua = longint'(a);
		ub = longint'(b);
		sa = (ua >= HALF) ? ua - FULL : ua;
		sb = (ub >= HALF) ? ub - FULL : ub;
		case (op)
			OP_ADD: begin
				usum = ua + ub;
				ssum = sa + sb;
			end
			OP_ADDC: begin
				usum = ua + ub + longint'(carry_prev);
				ssum = sa + sb + longint'(carry_prev);
			end
			OP_SUB: begin
				// Biased by 2^W, so a carry means a >= b
				usum = ua - ub + FULL;
				ssum = sa - sb;
			end
			OP_INC: begin
				usum = ua + 1;
				ssum = sa + 1;
			end
		endcase
		ovf = (ssum >= HALF) || (ssum < -HALF);
		return {usum >= FULL, (usum % FULL) == 0, ovf, W'(usum % FULL)};
	endfunction

	task automatic check_value(input string name, input logic [DW-1:0] actual,
			input logic [DW-1:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
			$display("Test failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic post_result(input string name, input logic [DW-1:0] actual,
			input logic [DW-1:0] expected);
		name_q.push_back(name);
		act_q.push_back(actual);
		exp_q.push_back(expected);
		->sample_ev;
	endtask

	task automatic wb_write(input logic [`WB_ADDR_WIDTH-1:0] adr, input logic [DW-1:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b1;
		wb_adr = adr;
		wb_wdata = data;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic wb_read(input logic [`WB_ADDR_WIDTH-1:0] adr, output logic [DW-1:0] data);
		@(negedge clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = 1'b0;
		wb_adr = adr;
		@(negedge clk);
		while (!wb_ack)
			@(negedge clk);
		data = wb_rdata;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
	endtask

	// One operation through the bus, then status and result read back
	// Status right after the control write sees done before it turns sticky
	task automatic run_op(input alu_op_t op, input logic [W-1:0] a, input logic [W-1:0] b);
		logic [DW-1:0] rd;
		last_exp = alu_model(op, a, b, model_carry);
		model_carry = last_exp[W+2];
		wb_write(`REG_OP_A, DW'(a));
		wb_write(`REG_OP_B, DW'(b));
		wb_write(`REG_CTRL, DW'(op));
		wb_read(`REG_STATUS, rd);
		post_result("status", rd, DW'({1'b1, last_exp[W], last_exp[W+1], last_exp[W+2]}));
		wb_read(`REG_RESULT, rd);
		post_result("result", rd, DW'(last_exp[W-1:0]));
	endtask

	initial begin
		forever begin
			@(sample_ev);
			while (act_q.size() > 0)
				check_value(name_q.pop_front(), act_q.pop_front(), exp_q.pop_front());
		end
	end

	initial begin : stimulus
		logic [DW-1:0] rd;
		seed = 32'h19b0;
		model_carry = 1'b0;
		last_exp = '0;
		reset = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_wdata = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		// Every address reads zero straight after reset
		for (int k = 0; k < 8; k++) begin
			wb_read(`WB_ADDR_WIDTH'(k), rd);
			post_result($sformatf("reg %0d after reset", k), rd, '0);
		end

		// Width limits
		run_op(OP_ADD, MAXV, W'(1));
		run_op(OP_ADD, '0, '0);
		run_op(OP_ADD, MAXV, MAXV);
		run_op(OP_INC, MAXV, W'(9));
		run_op(OP_ADD, MAXS, W'(1));

		// Carry chaining and borrow convention
		run_op(OP_ADD, MAXV, W'(2));
		run_op(OP_ADDC, W'(5), W'(6));
		run_op(OP_SUB, W'(3), W'(5));
		run_op(OP_ADDC, W'(1), W'(1));
		run_op(OP_SUB, MINS, W'(1));
		run_op(OP_SUB, MAXS, MAXV);
		run_op(OP_SUB, W'(7), W'(7));

		// Register read-back and sticky done
		wb_write(`REG_OP_A, 32'h0001_2345);
		wb_read(`REG_STATUS, rd);
		post_result("status done after operand write", DW'(rd[3]), '0);
		wb_read(`REG_OP_A, rd);
		post_result("op_a", rd, 32'h0001_2345);
		wb_write(`REG_OP_B, 32'hffff_ffff);
		wb_read(`REG_OP_B, rd);
		post_result("op_b", rd, DW'(MAXV));
		wb_write(`REG_RESULT, 32'h0000_1555);
		wb_read(`REG_RESULT, rd);
		post_result("result after write", rd, DW'(last_exp[W-1:0]));
		run_op(OP_SUB, W'(100), W'(1));
		wb_read(`REG_CTRL, rd);
		post_result("ctrl", rd, DW'(OP_SUB));

		for (int n = 0; n < N_RANDOM; n++)
			run_op(alu_op_t'(2'($random(seed))), W'($random(seed)), W'($random(seed)));

		// Let the compare process take the last results
		@(negedge clk);
		$display("Test passed");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+hdl
hdl/alu_pkg.sv
hdl/wb_pkg.sv
hdl/lf_prefix_tree.sv
hdl/prefix_adder.sv
hdl/alu_core.sv
hdl/wb_alu_regs.sv
hdl/alu_top.sv
tests/alu_props.sv
tests/alu_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = alu_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation run failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
